//--- hdl/cpu_pkg.sv
package cpu_pkg;

	localparam int xlen = 32;
	localparam int inst_w = 32;
	localparam int reg_addr_w = 5;
	localparam int opc_w = 12;

	// instruction field widths.
	localparam int fn_w = 6;
	localparam int imm_w = 16;
	localparam int jidx_w = 26;

	localparam logic [reg_addr_w-1:0] link_reg = 5'd31; // jal destination.

	// internal opcode is {major, funct}; funct is zero outside r-type.
	localparam logic [opc_w-1:0] op_nop = 12'h000;

	localparam logic [opc_w-1:0] op_add = {6'h00, 6'h20};
	localparam logic [opc_w-1:0] op_sub = {6'h00, 6'h22};
	localparam logic [opc_w-1:0] op_and = {6'h00, 6'h24};
	localparam logic [opc_w-1:0] op_or = {6'h00, 6'h25};
	localparam logic [opc_w-1:0] op_slt = {6'h00, 6'h2a};
	localparam logic [opc_w-1:0] op_jr = {6'h00, 6'h08};

	localparam logic [opc_w-1:0] op_addi = {6'h08, 6'h00};
	localparam logic [opc_w-1:0] op_lw = {6'h23, 6'h00};
	localparam logic [opc_w-1:0] op_sw = {6'h2b, 6'h00};
	localparam logic [opc_w-1:0] op_beq = {6'h04, 6'h00};
	localparam logic [opc_w-1:0] op_bne = {6'h05, 6'h00};
	localparam logic [opc_w-1:0] op_jal = {6'h03, 6'h00};

	localparam logic [xlen-1:0] pc_step = 32'd4; // sequential pc increment.

endpackage

//--- hdl/reg_file.sv
`timescale 1ns/100ps

module reg_file (
	input  logic clk,
	input  logic rst,
	input  logic [cpu_pkg::reg_addr_w-1:0] rd_addr_a,
	input  logic [cpu_pkg::reg_addr_w-1:0] rd_addr_b,
	output logic [cpu_pkg::xlen-1:0] rd_data_a,
	output logic [cpu_pkg::xlen-1:0] rd_data_b,
	input  logic wr_en,
	input  logic [cpu_pkg::reg_addr_w-1:0] wr_addr,
	input  logic [cpu_pkg::xlen-1:0] wr_data
);

	localparam int depth = 1 << cpu_pkg::reg_addr_w;

	logic [cpu_pkg::xlen-1:0] regs [depth];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < depth; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// no write bypass here, id_stage forwards from execute instead.
	assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
	assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

//--- hdl/id_stage.sv
`timescale 1ns/100ps

module id_stage (
	input  logic inst_valid,
	input  logic [cpu_pkg::inst_w-1:0] inst,
	input  logic [cpu_pkg::xlen-1:0] inst_pc,
	input  logic [cpu_pkg::xlen-1:0] inst_pfc,
	input  logic inst_predicted,
	output logic [cpu_pkg::reg_addr_w-1:0] rf_addr_a,
	output logic [cpu_pkg::reg_addr_w-1:0] rf_addr_b,
	input  logic [cpu_pkg::xlen-1:0] rf_data_a,
	input  logic [cpu_pkg::xlen-1:0] rf_data_b,
	input  logic fwd_en,
	input  logic [cpu_pkg::reg_addr_w-1:0] fwd_rd,
	input  logic [cpu_pkg::xlen-1:0] fwd_data,
	output logic [cpu_pkg::opc_w-1:0] id_opcode,
	output logic [cpu_pkg::reg_addr_w-1:0] id_rs1_ind,
	output logic [cpu_pkg::reg_addr_w-1:0] id_rs2_ind,
	output logic [cpu_pkg::reg_addr_w-1:0] id_rd_ind,
	output logic [cpu_pkg::xlen-1:0] id_pc,
	output logic [cpu_pkg::inst_w-1:0] id_inst,
	output logic [cpu_pkg::xlen-1:0] id_immed,
	output logic [cpu_pkg::xlen-1:0] id_rs1,
	output logic [cpu_pkg::xlen-1:0] id_rs2,
	output logic [cpu_pkg::xlen-1:0] id_pfc,
	output logic [cpu_pkg::xlen-1:0] id_forward_to_b,
	output logic id_regwrite,
	output logic id_memread,
	output logic id_memwrite,
	output logic id_predicted,
	output logic id_is_oper2_immed,
	output logic id_is_beq,
	output logic id_is_bne,
	output logic id_is_jr,
	output logic id_is_jal
);

	logic [cpu_pkg::fn_w-1:0] major;
	logic [cpu_pkg::fn_w-1:0] funct;
	logic [cpu_pkg::reg_addr_w-1:0] rs, rt, rd;
	logic [cpu_pkg::opc_w-1:0] raw_op;

	assign major = inst[cpu_pkg::inst_w-1 -: cpu_pkg::fn_w];
	assign funct = inst[cpu_pkg::fn_w-1:0];
	assign rs = inst[25:21];
	assign rt = inst[20:16];
	assign rd = inst[15:11];
	assign raw_op = {major, (major == '0) ? funct : {cpu_pkg::fn_w{1'b0}}};

	always_comb begin
		id_opcode = cpu_pkg::op_nop; // unknown encodings fall back to nop.
		id_rd_ind = '0;
		id_regwrite = 1'b0;
		id_memread = 1'b0;
		id_memwrite = 1'b0;
		id_is_oper2_immed = 1'b0;
		id_is_beq = 1'b0;
		id_is_bne = 1'b0;
		id_is_jr = 1'b0;
		id_is_jal = 1'b0;
		if (inst_valid) begin
			case (raw_op)
				cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
				cpu_pkg::op_or, cpu_pkg::op_slt: begin
					id_opcode = raw_op;
					id_rd_ind = rd;
					id_regwrite = 1'b1;
				end
				cpu_pkg::op_addi: begin
					id_opcode = raw_op;
					id_rd_ind = rt;
					id_regwrite = 1'b1;
					id_is_oper2_immed = 1'b1;
				end
				cpu_pkg::op_lw: begin
					id_opcode = raw_op;
					id_rd_ind = rt; // no writeback without a mem stage.
					id_memread = 1'b1;
					id_is_oper2_immed = 1'b1;
				end
				cpu_pkg::op_sw: begin
					id_opcode = raw_op;
					id_memwrite = 1'b1;
					id_is_oper2_immed = 1'b1;
				end
				cpu_pkg::op_beq: begin
					id_opcode = raw_op;
					id_is_beq = 1'b1;
				end
				cpu_pkg::op_bne: begin
					id_opcode = raw_op;
					id_is_bne = 1'b1;
				end
				cpu_pkg::op_jr: begin
					id_opcode = raw_op;
					id_is_jr = 1'b1;
				end
				cpu_pkg::op_jal: begin
					id_opcode = raw_op;
					id_rd_ind = cpu_pkg::link_reg;
					id_regwrite = 1'b1;
					id_is_jal = 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

	assign rf_addr_a = rs;
	assign rf_addr_b = rt;

	// the instruction in execute writes at the end of this cycle.
	assign id_rs1 = (fwd_en && fwd_rd == rs && rs != '0) ? fwd_data : rf_data_a;
	assign id_rs2 = (fwd_en && fwd_rd == rt && rt != '0) ? fwd_data : rf_data_b;
	assign id_forward_to_b = id_memwrite ? id_rs2 : '0; // store data.

	assign id_immed = {{(cpu_pkg::xlen-cpu_pkg::imm_w){inst[cpu_pkg::imm_w-1]}},
		inst[cpu_pkg::imm_w-1:0]};
	assign id_rs1_ind = rs;
	assign id_rs2_ind = rt;
	assign id_pc = inst_pc;
	assign id_pfc = inst_pfc;
	assign id_inst = inst_valid ? inst : '0;
	assign id_predicted = inst_valid & inst_predicted;

endmodule

//--- hdl/id_ex_buffer.sv
`timescale 1ns/100ps

module id_ex_buffer (
	input  logic clk,
	input  logic rst,
	input  logic flush,
	input  logic [cpu_pkg::opc_w-1:0] id_opcode,
	input  logic [cpu_pkg::reg_addr_w-1:0] id_rs1_ind,
	input  logic [cpu_pkg::reg_addr_w-1:0] id_rs2_ind,
	input  logic [cpu_pkg::reg_addr_w-1:0] id_rd_ind,
	input  logic [cpu_pkg::xlen-1:0] id_pc,
	input  logic [cpu_pkg::inst_w-1:0] id_inst,
	input  logic [cpu_pkg::xlen-1:0] id_immed,
	input  logic [cpu_pkg::xlen-1:0] id_rs1,
	input  logic [cpu_pkg::xlen-1:0] id_rs2,
	input  logic [cpu_pkg::xlen-1:0] id_pfc,
	input  logic [cpu_pkg::xlen-1:0] id_forward_to_b,
	input  logic id_regwrite,
	input  logic id_memread,
	input  logic id_memwrite,
	input  logic id_predicted,
	input  logic id_is_oper2_immed,
	input  logic id_is_beq,
	input  logic id_is_bne,
	input  logic id_is_jr,
	input  logic id_is_jal,
	output logic [cpu_pkg::opc_w-1:0] ex_opcode,
	output logic [cpu_pkg::reg_addr_w-1:0] ex_rs1_ind,
	output logic [cpu_pkg::reg_addr_w-1:0] ex_rs2_ind,
	output logic [cpu_pkg::reg_addr_w-1:0] ex_rd_ind,
	output logic [cpu_pkg::xlen-1:0] ex_pc,
	output logic [cpu_pkg::inst_w-1:0] ex_inst,
	output logic [cpu_pkg::xlen-1:0] ex_immed,
	output logic [cpu_pkg::xlen-1:0] ex_rs1,
	output logic [cpu_pkg::xlen-1:0] ex_rs2,
	output logic [cpu_pkg::xlen-1:0] ex_pfc,
	output logic [cpu_pkg::xlen-1:0] ex_forward_to_b,
	output logic ex_regwrite,
	output logic ex_memread,
	output logic ex_memwrite,
	output logic ex_predicted,
	output logic ex_is_oper2_immed,
	output logic ex_is_beq,
	output logic ex_is_bne,
	output logic ex_is_jr,
	output logic ex_is_jal
);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			{ex_opcode, ex_rs1_ind, ex_rs2_ind, ex_rd_ind, ex_pc, ex_inst, ex_immed, ex_rs1,
				ex_rs2, ex_pfc, ex_forward_to_b, ex_regwrite, ex_memread, ex_memwrite,
				ex_predicted, ex_is_oper2_immed, ex_is_beq, ex_is_bne, ex_is_jr,
				ex_is_jal} <= '0;
		end else if (flush) begin // all zeros is a nop bubble.
			{ex_opcode, ex_rs1_ind, ex_rs2_ind, ex_rd_ind, ex_pc, ex_inst, ex_immed, ex_rs1,
				ex_rs2, ex_pfc, ex_forward_to_b, ex_regwrite, ex_memread, ex_memwrite,
				ex_predicted, ex_is_oper2_immed, ex_is_beq, ex_is_bne, ex_is_jr,
				ex_is_jal} <= '0;
		end else begin
			ex_opcode <= id_opcode;
			ex_rs1_ind <= id_rs1_ind;
			ex_rs2_ind <= id_rs2_ind;
			ex_rd_ind <= id_rd_ind;
			ex_pc <= id_pc;
			ex_inst <= id_inst;
			ex_immed <= id_immed;
			ex_rs1 <= id_rs1;
			ex_rs2 <= id_rs2;
			ex_pfc <= id_pfc;
			ex_forward_to_b <= id_forward_to_b;
			ex_regwrite <= id_regwrite;
			ex_memread <= id_memread;
			ex_memwrite <= id_memwrite;
			ex_predicted <= id_predicted;
			ex_is_oper2_immed <= id_is_oper2_immed;
			ex_is_beq <= id_is_beq;
			ex_is_bne <= id_is_bne;
			ex_is_jr <= id_is_jr;
			ex_is_jal <= id_is_jal;
		end
	end

endmodule

//--- hdl/ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
	input  logic [cpu_pkg::opc_w-1:0] ex_opcode,
	input  logic [cpu_pkg::reg_addr_w-1:0] ex_rd_ind,
	input  logic [cpu_pkg::xlen-1:0] ex_pc,
	input  logic [cpu_pkg::inst_w-1:0] ex_inst,
	input  logic [cpu_pkg::xlen-1:0] ex_immed,
	input  logic [cpu_pkg::xlen-1:0] ex_rs1,
	input  logic [cpu_pkg::xlen-1:0] ex_rs2,
	input  logic [cpu_pkg::xlen-1:0] ex_pfc,
	input  logic [cpu_pkg::xlen-1:0] ex_forward_to_b,
	input  logic ex_regwrite,
	input  logic ex_memread,
	input  logic ex_memwrite,
	input  logic ex_is_oper2_immed,
	input  logic ex_is_beq,
	input  logic ex_is_bne,
	input  logic ex_is_jr,
	input  logic ex_is_jal,
	output logic wb_en,
	output logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
	output logic [cpu_pkg::xlen-1:0] wb_data,
	output logic fwd_en,
	output logic [cpu_pkg::reg_addr_w-1:0] fwd_rd,
	output logic [cpu_pkg::xlen-1:0] fwd_data,
	output logic mem_read,
	output logic mem_write,
	output logic [cpu_pkg::xlen-1:0] mem_addr,
	output logic [cpu_pkg::xlen-1:0] mem_wdata,
	output logic redirect,
	output logic [cpu_pkg::xlen-1:0] redirect_pc
);

	logic [cpu_pkg::xlen-1:0] op_b, alu_res;
	logic [cpu_pkg::xlen-1:0] pc_seq, br_target, jal_target, next_pc;
	logic is_ctrl, eq;

	assign op_b = ex_is_oper2_immed ? ex_immed : ex_rs2;

	always_comb begin
		case (ex_opcode)
			cpu_pkg::op_add, cpu_pkg::op_addi,
			cpu_pkg::op_lw, cpu_pkg::op_sw: alu_res = ex_rs1 + op_b; // also address gen.
			cpu_pkg::op_sub: alu_res = ex_rs1 - op_b;
			cpu_pkg::op_and: alu_res = ex_rs1 & op_b;
			cpu_pkg::op_or: alu_res = ex_rs1 | op_b;
			cpu_pkg::op_slt: alu_res = {{(cpu_pkg::xlen-1){1'b0}},
				$signed(ex_rs1) < $signed(op_b)};
			default: alu_res = '0;
		endcase
	end

	assign pc_seq = ex_pc + cpu_pkg::pc_step;
	assign br_target = pc_seq + {ex_immed[cpu_pkg::xlen-3:0], 2'b00}; // word offset.
	assign jal_target = {pc_seq[cpu_pkg::xlen-1:cpu_pkg::jidx_w+2],
		ex_inst[cpu_pkg::jidx_w-1:0], 2'b00};
	assign eq = (ex_rs1 == ex_rs2);

	always_comb begin
		if (ex_is_jr) begin
			next_pc = ex_rs1;
		end else if (ex_is_jal) begin
			next_pc = jal_target;
		end else if ((ex_is_beq && eq) || (ex_is_bne && !eq)) begin
			next_pc = br_target;
		end else begin
			next_pc = pc_seq;
		end
	end

	// the front end's next fetch is checked against the resolved path.
	assign is_ctrl = ex_is_beq | ex_is_bne | ex_is_jr | ex_is_jal;
	assign redirect = is_ctrl && (next_pc != ex_pfc);
	assign redirect_pc = next_pc;

	assign wb_en = ex_regwrite && (ex_rd_ind != '0); // writes to r0 are dropped.
	assign wb_rd = ex_rd_ind;
	assign wb_data = ex_is_jal ? pc_seq : alu_res; // link address.

	assign fwd_en = wb_en;
	assign fwd_rd = wb_rd;
	assign fwd_data = wb_data;

	assign mem_read = ex_memread;
	assign mem_write = ex_memwrite;
	assign mem_addr = alu_res;
	assign mem_wdata = ex_forward_to_b;

endmodule

//--- hdl/decode_execute_top.sv
`timescale 1ns/100ps

module decode_execute_top (
	input  logic clk,
	input  logic rst,
	input  logic inst_valid,
	input  logic [cpu_pkg::inst_w-1:0] inst,
	input  logic [cpu_pkg::xlen-1:0] inst_pc,
	input  logic [cpu_pkg::xlen-1:0] inst_pfc,
	input  logic inst_predicted,
	output logic wb_en,
	output logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
	output logic [cpu_pkg::xlen-1:0] wb_data,
	output logic mem_read,
	output logic mem_write,
	output logic [cpu_pkg::xlen-1:0] mem_addr,
	output logic [cpu_pkg::xlen-1:0] mem_wdata,
	output logic redirect,
	output logic [cpu_pkg::xlen-1:0] redirect_pc
);

	logic [cpu_pkg::reg_addr_w-1:0] rf_addr_a, rf_addr_b, fwd_rd;
	logic [cpu_pkg::xlen-1:0] rf_data_a, rf_data_b, fwd_data;
	logic fwd_en;

	logic [cpu_pkg::opc_w-1:0] id_opcode, ex_opcode;
	logic [cpu_pkg::reg_addr_w-1:0] id_rs1_ind, id_rs2_ind, id_rd_ind, ex_rd_ind;
	logic [cpu_pkg::xlen-1:0] id_pc, id_immed, id_rs1, id_rs2, id_pfc, id_forward_to_b;
	logic [cpu_pkg::xlen-1:0] ex_pc, ex_immed, ex_rs1, ex_rs2, ex_pfc, ex_forward_to_b;
	logic [cpu_pkg::inst_w-1:0] id_inst, ex_inst;
	logic id_regwrite, id_memread, id_memwrite, id_predicted, id_is_oper2_immed;
	logic id_is_beq, id_is_bne, id_is_jr, id_is_jal;
	logic ex_regwrite, ex_memread, ex_memwrite, ex_is_oper2_immed;
	logic ex_is_beq, ex_is_bne, ex_is_jr, ex_is_jal;

	reg_file i_reg_file (
		.clk, .rst,
		.rd_addr_a(rf_addr_a), .rd_addr_b(rf_addr_b),
		.rd_data_a(rf_data_a), .rd_data_b(rf_data_b),
		.wr_en(wb_en), .wr_addr(wb_rd), .wr_data(wb_data)
	);

	id_stage i_id_stage (
		.inst_valid, .inst, .inst_pc, .inst_pfc, .inst_predicted,
		.rf_addr_a, .rf_addr_b, .rf_data_a, .rf_data_b,
		.fwd_en, .fwd_rd, .fwd_data,
		.id_opcode, .id_rs1_ind, .id_rs2_ind, .id_rd_ind, .id_pc, .id_inst, .id_immed,
		.id_rs1, .id_rs2, .id_pfc, .id_forward_to_b, .id_regwrite, .id_memread,
		.id_memwrite, .id_predicted, .id_is_oper2_immed, .id_is_beq, .id_is_bne,
		.id_is_jr, .id_is_jal
	);

	id_ex_buffer i_id_ex_buffer (
		.clk, .rst, .flush(redirect),
		.id_opcode, .id_rs1_ind, .id_rs2_ind, .id_rd_ind, .id_pc, .id_inst, .id_immed,
		.id_rs1, .id_rs2, .id_pfc, .id_forward_to_b, .id_regwrite, .id_memread,
		.id_memwrite, .id_predicted, .id_is_oper2_immed, .id_is_beq, .id_is_bne,
		.id_is_jr, .id_is_jal,
		.ex_opcode, .ex_rs1_ind(), .ex_rs2_ind(), .ex_rd_ind, .ex_pc, .ex_inst, .ex_immed,
		.ex_rs1, .ex_rs2, .ex_pfc, .ex_forward_to_b, .ex_regwrite, .ex_memread,
		.ex_memwrite, .ex_predicted(), .ex_is_oper2_immed, .ex_is_beq, .ex_is_bne,
		.ex_is_jr, .ex_is_jal
	);

	ex_stage i_ex_stage (
		.ex_opcode, .ex_rd_ind, .ex_pc, .ex_inst, .ex_immed, .ex_rs1, .ex_rs2, .ex_pfc,
		.ex_forward_to_b, .ex_regwrite, .ex_memread, .ex_memwrite, .ex_is_oper2_immed,
		.ex_is_beq, .ex_is_bne, .ex_is_jr, .ex_is_jal,
		.wb_en, .wb_rd, .wb_data,
		.fwd_en, .fwd_rd, .fwd_data,
		.mem_read, .mem_write, .mem_addr, .mem_wdata,
		.redirect, .redirect_pc
	);

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic rst
);

	localparam int half_period = 2; // 4 ns clock.
	localparam int reset_cycles = 3;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0; // released away from the active edge.
	end

endmodule

//--- dv/decode_execute_assert.sv
`timescale 1ns/100ps

module decode_execute_assert (
	input logic clk,
	input logic rst,
	input logic [cpu_pkg::opc_w-1:0] ex_opcode,
	input logic redirect,
	input logic wb_en,
	input logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
	input logic mem_read,
	input logic mem_write
);

	int fail_count = 0;

	a_no_redirect_on_bubble: assert property (@(posedge clk) disable iff (rst)
		(ex_opcode == cpu_pkg::op_nop) |-> !redirect)
		else begin
			fail_count++;
			$error("redirect raised while the ID/EX buffer holds a nop");
		end

	a_one_mem_strobe: assert property (@(posedge clk) disable iff (rst)
		!(mem_read && mem_write))
		else begin
			fail_count++;
			$error("mem_read and mem_write raised together");
		end

	a_no_write_to_r0: assert property (@(posedge clk) disable iff (rst)
		wb_en |-> (wb_rd != '0))
		else begin
			fail_count++;
			$error("writeback enabled with register 0 as destination");
		end

	// the slot behind a redirect must be a bubble.
	a_flush_quiet: assert property (@(posedge clk) disable iff (rst)
		redirect |=> !(wb_en || mem_read || mem_write))
		else begin
			fail_count++;
			$error("writeback or memory strobe in the cycle after a redirect");
		end

endmodule

//--- dv/decode_execute_tb.sv
`timescale 1ns/100ps

module decode_execute_tb;

	localparam int max_cycles = 400; // about 250 cycles of tests plus margin.
	localparam int rand_count = 200;
	localparam int seed = 2644;

	logic clk, rst;
	logic inst_valid, inst_predicted;
	logic [cpu_pkg::inst_w-1:0] inst;
	logic [cpu_pkg::xlen-1:0] inst_pc, inst_pfc;
	logic wb_en, mem_read, mem_write, redirect;
	logic [cpu_pkg::reg_addr_w-1:0] wb_rd;
	logic [cpu_pkg::xlen-1:0] wb_data, mem_addr, mem_wdata, redirect_pc;

	logic [cpu_pkg::xlen-1:0] shadow [32];
	logic [cpu_pkg::xlen-1:0] pc;
	// expected response of the instruction now in execute.
	logic e_wb_en, e_mem_read, e_mem_write, e_redirect, e_is_ctrl;
	logic [cpu_pkg::reg_addr_w-1:0] e_wb_rd;
	logic [cpu_pkg::xlen-1:0] e_wb_data, e_mem_addr, e_mem_wdata, e_redirect_pc;
	int errors = 0;
	int cycles = 0;

	tb_clock i_clock (.clk, .rst);

	decode_execute_top i_dut (
		.clk, .rst, .inst_valid, .inst, .inst_pc, .inst_pfc, .inst_predicted,
		.wb_en, .wb_rd, .wb_data, .mem_read, .mem_write, .mem_addr, .mem_wdata,
		.redirect, .redirect_pc
	);

	bind decode_execute_top decode_execute_assert i_assert (
		.clk, .rst, .ex_opcode, .redirect, .wb_en, .wb_rd, .mem_read, .mem_write
	);

	task automatic flag(input string msg);
		errors++;
		$display("** Error @%0t: %s", $time, msg);
	endtask

	task automatic check_ex();
		assert (wb_en === e_wb_en)
			else flag($sformatf("wb_en is %b, expected %b", wb_en, e_wb_en));
		assert (!e_wb_en || (wb_rd === e_wb_rd && wb_data === e_wb_data))
			else flag($sformatf("writeback r%0d = %h, expected r%0d = %h",
				wb_rd, wb_data, e_wb_rd, e_wb_data));
		assert (mem_read === e_mem_read && mem_write === e_mem_write)
			else flag($sformatf("strobes read %b write %b, expected %b %b",
				mem_read, mem_write, e_mem_read, e_mem_write));
		assert (!(e_mem_read || e_mem_write) || mem_addr === e_mem_addr)
			else flag($sformatf("mem_addr %h, expected %h", mem_addr, e_mem_addr));
		assert (!e_mem_write || mem_wdata === e_mem_wdata)
			else flag($sformatf("mem_wdata %h, expected %h", mem_wdata, e_mem_wdata));
		assert (redirect === e_redirect)
			else flag($sformatf("redirect is %b, expected %b", redirect, e_redirect));
		assert (!e_is_ctrl || redirect_pc === e_redirect_pc)
			else flag($sformatf("redirect_pc %h, expected %h", redirect_pc, e_redirect_pc));
	endtask

	// checks the instruction in execute, then drives the next one into decode.
	task automatic issue(input logic [cpu_pkg::opc_w-1:0] op, input int rs, input int rt,
		input int rd, input int imm, input int bad_pfc);
		logic [4:0] s, t, d, dest;
		logic [15:0] im;
		logic [31:0] a, b, sext, res, seq, next_pc, pfc;
		logic writes, flushed;
		@(negedge clk);
		check_ex();
		flushed = e_redirect; // the slot after a redirect becomes a bubble.
		s = 5'(rs);
		t = 5'(rt);
		d = 5'(rd);
		im = 16'(imm);
		a = shadow[s];
		b = shadow[t];
		sext = {{16{im[15]}}, im};
		seq = pc + 32'd4;
		res = '0;
		next_pc = seq;
		case (op)
			cpu_pkg::op_add: res = a + b;
			cpu_pkg::op_sub: res = a - b;
			cpu_pkg::op_and: res = a & b;
			cpu_pkg::op_or: res = a | b;
			cpu_pkg::op_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			cpu_pkg::op_beq: next_pc = (a == b) ? seq + (sext << 2) : seq;
			cpu_pkg::op_bne: next_pc = (a != b) ? seq + (sext << 2) : seq;
			cpu_pkg::op_jr: next_pc = a;
			cpu_pkg::op_jal: next_pc = {seq[31:28], s, t, im, 2'b00};
			default: res = a + sext; // addi, lw and sw.
		endcase
		writes = op inside {cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
			cpu_pkg::op_or, cpu_pkg::op_slt, cpu_pkg::op_addi, cpu_pkg::op_jal};
		dest = (op == cpu_pkg::op_addi) ? t : (op == cpu_pkg::op_jal) ? cpu_pkg::link_reg : d;
		pfc = (bad_pfc != 0) ? next_pc + 32'h40 : next_pc;
		inst_valid = (op != cpu_pkg::op_nop);
		inst = (op[11:6] == 6'h00) ? {6'h00, s, t, d, 5'h00, op[5:0]} : {op[11:6], s, t, im};
		inst_pc = pc;
		inst_pfc = pfc;
		inst_predicted = (pfc != seq);
		e_is_ctrl = !flushed && (op inside {cpu_pkg::op_beq, cpu_pkg::op_bne,
			cpu_pkg::op_jr, cpu_pkg::op_jal});
		e_redirect = e_is_ctrl && (bad_pfc != 0);
		e_redirect_pc = next_pc;
		e_wb_en = !flushed && writes && (dest != 5'd0);
		e_wb_rd = dest;
		e_wb_data = (op == cpu_pkg::op_jal) ? seq : res;
		e_mem_read = !flushed && (op == cpu_pkg::op_lw);
		e_mem_write = !flushed && (op == cpu_pkg::op_sw);
		e_mem_addr = res;
		e_mem_wdata = b;
		if (e_wb_en) begin
			shadow[dest] = e_wb_data;
		end
		pc = seq;
	endtask

	function automatic logic [cpu_pkg::opc_w-1:0] pick_op(input int k);
		case (k)
			0: return cpu_pkg::op_add;
			1: return cpu_pkg::op_sub;
			2: return cpu_pkg::op_and;
			3: return cpu_pkg::op_or;
			4: return cpu_pkg::op_slt;
			default: return cpu_pkg::op_addi;
		endcase
	endfunction

	initial begin
		void'($urandom(seed));
		inst_valid = 1'b0;
		inst = '0;
		inst_pc = '0;
		inst_pfc = '0;
		inst_predicted = 1'b0;
		pc = 32'h0000_1000;
		{e_wb_en, e_mem_read, e_mem_write, e_redirect, e_is_ctrl} = '0;
		e_wb_rd = '0;
		{e_wb_data, e_mem_addr, e_mem_wdata, e_redirect_pc} = '0;
		foreach (shadow[i]) shadow[i] = '0;
		@(negedge rst);
		issue(cpu_pkg::op_addi, 0, 1, 0, 5, 0);
		issue(cpu_pkg::op_addi, 0, 2, 0, -3, 0);
		issue(cpu_pkg::op_addi, 0, 3, 0, 5, 0);
		issue(cpu_pkg::op_addi, 0, 4, 0, 'h100, 0);
		issue(cpu_pkg::op_addi, 0, 5, 0, 'h2000, 0); // jr target.
		issue(cpu_pkg::op_add, 1, 2, 6, 0, 0);
		issue(cpu_pkg::op_sub, 6, 1, 7, 0, 0);
		issue(cpu_pkg::op_and, 7, 4, 8, 0, 0);
		issue(cpu_pkg::op_or, 8, 7, 9, 0, 0);
		issue(cpu_pkg::op_slt, 7, 1, 10, 0, 0);
		issue(cpu_pkg::op_addi, 10, 10, 0, 7, 0);
		issue(cpu_pkg::op_addi, 4, 11, 0, 8, 0);
		issue(cpu_pkg::op_sw, 4, 11, 0, 4, 0); // store data forwarded.
		issue(cpu_pkg::op_lw, 4, 12, 0, -8, 0);
		issue(cpu_pkg::op_beq, 1, 3, 0, 3, 0);
		issue(cpu_pkg::op_beq, 1, 3, 0, 3, 1);
		issue(cpu_pkg::op_addi, 0, 13, 0, 99, 0); // wrong path.
		issue(cpu_pkg::op_beq, 1, 2, 0, -2, 0);
		issue(cpu_pkg::op_beq, 1, 2, 0, -2, 1);
		issue(cpu_pkg::op_add, 1, 1, 13, 0, 0);
		issue(cpu_pkg::op_bne, 1, 2, 0, 6, 0);
		issue(cpu_pkg::op_bne, 1, 2, 0, 6, 1);
		issue(cpu_pkg::op_sw, 4, 1, 0, 0, 0);
		issue(cpu_pkg::op_bne, 1, 3, 0, 6, 0);
		issue(cpu_pkg::op_bne, 1, 3, 0, 6, 1);
		issue(cpu_pkg::op_lw, 4, 13, 0, 0, 0);
		issue(cpu_pkg::op_addi, 13, 14, 0, 1, 0);
		issue(cpu_pkg::op_jal, 0, 0, 0, 'h40, 0);
		issue(cpu_pkg::op_jr, 31, 0, 0, 0, 1); // link value forwarded.
		issue(cpu_pkg::op_or, 31, 0, 15, 0, 0);
		issue(cpu_pkg::op_jal, 1, 2, 0, 'h80, 1);
		issue(cpu_pkg::op_sub, 31, 1, 16, 0, 0);
		issue(cpu_pkg::op_jr, 5, 0, 0, 0, 0);
		issue(cpu_pkg::op_jr, 5, 0, 0, 0, 1);
		issue(cpu_pkg::op_add, 5, 5, 17, 0, 0);
		issue(cpu_pkg::op_add, 31, 0, 18, 0, 0);
		for (int i = 0; i < rand_count; i++) begin
			issue(pick_op($urandom_range(5, 0)), $urandom_range(31, 0), $urandom_range(31, 0),
				$urandom_range(31, 0), $urandom_range(65535, 0), 0);
		end
		issue(cpu_pkg::op_nop, 0, 0, 0, 0, 0);
		issue(cpu_pkg::op_nop, 0, 0, 0, 0, 0);
		$display("errors: %0d, assertion failures: %0d", errors, i_dut.i_assert.fail_count);
		if (errors == 0 && i_dut.i_assert.fail_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		while (cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the test did not finish within %0d cycles", max_cycles);
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- verilog.f
hdl/cpu_pkg.sv
hdl/reg_file.sv
hdl/id_stage.sv
hdl/id_ex_buffer.sv
hdl/ex_stage.sv
hdl/decode_execute_top.sv
dv/tb_clock.sv
dv/decode_execute_assert.sv
dv/decode_execute_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= decode_execute_tb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps
SIM_ARGS ?= +verilator+error+limit+100

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "result: failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "result: no verdict in $(LOG)"; exit 1; fi
	@echo "result: passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
